/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_cluster_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(wildcard src/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
src/tomasulo_pkg.sv
src/rename_table.sv
src/alu_rs.sv
src/alu_unit.sv
src/alu_cluster_top.sv
sim/alu_cluster_properties.sv
sim/alu_cluster_tb.sv

/* sim/alu_cluster_properties.sv */
`timescale 1ns/1ns

module alu_cluster_properties
    import tomasulo_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input logic      flush_i,
    input logic      dispatch_ready_i,
    input logic      issue_valid_i,
    input rs_entry_t issue_i,
    input cdb_t      ext_wb_i,
    input cdb_t      cdb_i
);

    int fail_cnt = 0;

    // reset and flush drop every held result
    quiet_after_clear: assert property (
        @(posedge clk) (!rst_n_i || flush_i) |=> !cdb_i.valid
    ) else begin
        $error("cdb valid in the cycle after reset or flush");
        fail_cnt++;
    end

    ext_priority: assert property (
        @(posedge clk) disable iff (!rst_n_i) ext_wb_i.valid |-> cdb_i == ext_wb_i
    ) else begin
        $error("external producer did not own the cdb");
        fail_cnt++;
    end

    // reset and flush empty the rs and free every tag
    ready_after_clear: assert property (
        @(posedge clk) (!rst_n_i || flush_i) |=> dispatch_ready_i && !issue_valid_i
    ) else begin
        $error("dispatch not ready or issue offered in the cycle after reset or flush");
        fail_cnt++;
    end

    // only complete entries may leave the rs
    issue_operands_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            issue_valid_i |-> issue_i.src1.ready && issue_i.src2.ready
    ) else begin
        $error("issue offered with an operand still waiting");
        fail_cnt++;
    end

endmodule

bind alu_cluster_top alu_cluster_properties u_props (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .dispatch_ready_i (dispatch_ready_o),
    .issue_valid_i    (issue_valid),
    .issue_i          (issue),
    .ext_wb_i         (ext_wb_i),
    .cdb_i            (cdb_o)
);

/* sim/alu_cluster_tb.sv */
`timescale 1ns/1ns

module alu_cluster_tb
    import tomasulo_pkg::*;
();

    localparam int N_RAND     = 40;
    localparam int N_CHAIN    = 20;
    localparam int N_DEPS     = 6;
    localparam int N_BURST    = 8;
    localparam int N_FLUSH    = 10;
    localparam int N_INSTR    = N_RAND + N_CHAIN + 1 + N_DEPS + 2 * N_BURST + 2 * N_FLUSH;
    localparam int MAX_CYCLES = 40 * N_INSTR + 200;
    // only external ops write this register, random alu ops never read it
    localparam logic [REG_W-1:0] EXT_REG = 4'd15;

    typedef struct packed {
        logic [31:0]      due;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } ext_ret_t;

    logic      clk;
    logic      rst_n_i;
    logic      flush_i;
    logic      dispatch_valid_i;
    dispatch_t dispatch_i;
    logic      dispatch_ready_o;
    cdb_t      ext_wb_i = '0;
    cdb_t      cdb_o;

    logic [31:0]     lcg_state = 32'h1283;
    int              cycle = 0;
    int              checked = 0;
    int              errors = 0;
    int              seq_errors = 0;
    int              stall_cycles = 0;
    logic [XLEN-1:0] ext_val_cur;
    int              ext_due_cur;
    ext_ret_t        ext_q[$];
    cdb_t            next_ext;

    // in-order model, spec is the program-order view, arch is what has been broadcast
    logic [XLEN-1:0]     spec_val [NUM_ARCH_REGS] = '{default: '0};
    logic [XLEN-1:0]     arch_val [NUM_ARCH_REGS] = '{default: '0};
    logic                wr_busy  [NUM_ARCH_REGS] = '{default: 1'b0};
    logic [TAG_W-1:0]    wr_tag   [NUM_ARCH_REGS] = '{default: '0};
    logic [XLEN-1:0]     exp_val  [NUM_TAGS] = '{default: '0};
    logic [NUM_TAGS-1:0] exp_pend = '0;
    int                  pend_cnt = 0;
    logic [TAG_W-1:0]    next_tag = '0;

    alu_cluster_top #(
        .RS_DEPTH (4)
    ) u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .ext_wb_i         (ext_wb_i),
        .cdb_o            (cdb_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    function automatic alu_op_e rand_op();
        return alu_op_e'(4'(pick(10)));
    endfunction

    // sources stay below EXT_REG
    function automatic dispatch_t rand_alu(input alu_op_e op);
        dispatch_t d;
        d.op      = op;
        d.rd      = REG_W'(1 + pick(14));
        d.rs1     = REG_W'(pick(15));
        d.rs2     = REG_W'(pick(15));
        d.imm     = lcg_next();
        d.use_imm = (pick(2) == 1);
        return d;
    endfunction

    function automatic dispatch_t ext_instr();
        dispatch_t d;
        d         = '0;
        d.op      = op_ext;
        d.rd      = EXT_REG;
        return d;
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input alu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << sh;
            op_srl:  return a >> sh;
            op_sra:  return XLEN'($signed(a) >>> sh);
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_broadcast();
        checked++;
        assert (exp_pend[cdb_o.tag]) else begin
            $display("tag %0h was broadcast on cdb_o while not in flight", cdb_o.tag);
            errors++;
        end
        if (exp_pend[cdb_o.tag]) begin
            assert (cdb_o.value == exp_val[cdb_o.tag]) else begin
                $display("CHECK FAILED cdb_o.value tag %0h expected %08h actual %08h",
                         cdb_o.tag, exp_val[cdb_o.tag], cdb_o.value);
                errors++;
            end
            exp_pend[cdb_o.tag] = 1'b0;
            pend_cnt--;
            // a broadcast in the flush cycle is not written back
            if (!flush_i) begin
                for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                    if (wr_busy[r] && wr_tag[r] == cdb_o.tag) begin
                        arch_val[r] = exp_val[cdb_o.tag];
                        wr_busy[r]  = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic record_accept();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        a   = spec_val[dispatch_i.rs1];
        b   = dispatch_i.use_imm ? dispatch_i.imm : spec_val[dispatch_i.rs2];
        res = model_alu(dispatch_i.op, a, b);
        if (dispatch_i.op == op_ext) begin
            res = ext_val_cur;
            ext_q.push_back('{due: 32'(ext_due_cur), tag: next_tag, value: ext_val_cur});
        end
        exp_val[next_tag]  = res;
        exp_pend[next_tag] = 1'b1;
        pend_cnt++;
        if (dispatch_i.rd != '0) begin
            spec_val[dispatch_i.rd] = res;
            wr_busy[dispatch_i.rd]  = 1'b1;
            wr_tag[dispatch_i.rd]   = next_tag;
        end
        next_tag++;
    endtask

    // registers without a pending writer already hold their spec value
    task automatic clear_model();
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            spec_val[r] = arch_val[r];
            wr_busy[r]  = 1'b0;
        end
        exp_pend = '0;
        pend_cnt = 0;
        next_tag = '0;
        ext_q.delete();
    endtask

    // monitor at the falling edge, external producer driven after the next rising edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (!dispatch_ready_o) begin
                stall_cycles++;
            end
            if (cdb_o.valid) begin
                check_broadcast();
            end
            if (flush_i) begin
                clear_model();
            end else if (dispatch_valid_i && dispatch_ready_o) begin
                record_accept();
            end
        end
        next_ext = '0;
        if (ext_q.size() > 0 && ext_q[0].due <= 32'(cycle + 1)) begin
            next_ext.valid = 1'b1;
            next_ext.tag   = ext_q[0].tag;
            next_ext.value = ext_q[0].value;
            void'(ext_q.pop_front());
        end
        @(posedge clk);
        #2;
        ext_wb_i = next_ext;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d tags still in flight", cycle, pend_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // hold valid until the handshake, xval and xdue only matter for op_ext
    task automatic send(input dispatch_t d, input logic [XLEN-1:0] xval, input int xdue);
        dispatch_i       = d;
        ext_val_cur      = xval;
        ext_due_cur      = xdue;
        dispatch_valid_i = 1'b1;
        do begin
            @(negedge clk);
        end while (!dispatch_ready_o);
        @(posedge clk);
        #2;
        dispatch_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (pend_cnt != 0) begin
            wait_cycles(1);
        end
    endtask

    initial begin
        dispatch_t        d;
        logic [REG_W-1:0] prev;
        int               due;
        int               stall_before;
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        ext_val_cur      = '0;
        ext_due_cur      = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        wait_cycles(2);

        // every opcode, register and immediate forms
        for (int i = 0; i < N_RAND; i++) begin
            send(rand_alu(alu_op_e'(4'(i % 10))), '0, 0);
        end
        drain();

        // chains through rd, random gaps hit both rs capture and dispatch bypass
        d = rand_alu(op_add);
        for (int i = 0; i < N_CHAIN; i++) begin
            prev  = d.rd;
            d     = rand_alu(rand_op());
            d.rs1 = prev;
            send(d, '0, 0);
            if (pick(2) == 1) begin
                wait_cycles(1);
            end
        end
        drain();

        // late external result with waiting dependents
        send(ext_instr(), lcg_next(), cycle + 30);
        for (int i = 0; i < N_DEPS; i++) begin
            d     = rand_alu(rand_op());
            d.rs1 = EXT_REG;
            send(d, '0, 0);
        end
        drain();

        // external burst holds the bus while alu work piles up
        stall_before = stall_cycles;
        due          = cycle + N_BURST + 2;
        for (int i = 0; i < N_BURST; i++) begin
            send(ext_instr(), lcg_next(), due);
        end
        for (int i = 0; i < N_BURST; i++) begin
            send(rand_alu(rand_op()), '0, 0);
        end
        drain();
        assert (stall_cycles > stall_before) else begin
            $display("dispatch_ready_o never fell while the external producer held the bus");
            seq_errors++;
        end

        // flush with alu work and a never returned external op in flight
        for (int i = 0; i < N_FLUSH; i++) begin
            if (i == 3) begin
                send(ext_instr(), lcg_next(), cycle + 400);
            end else begin
                send(rand_alu(rand_op()), '0, 0);
            end
        end
        flush_i = 1'b1;
        wait_cycles(1);
        flush_i = 1'b0;
        for (int i = 0; i < N_FLUSH; i++) begin
            d = rand_alu(rand_op());
            if (i == 0) begin
                d.rs1 = EXT_REG;
            end
            send(d, '0, 0);
        end
        drain();
        wait_cycles(4);

        $display("broadcasts checked %0d, value errors %0d, sequence errors %0d, assertion failures %0d",
                 checked, errors, seq_errors, u_dut.u_props.fail_cnt);
        if (errors == 0 && seq_errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/alu_cluster_top.sv */
`timescale 1ns/1ns

module alu_cluster_top
    import tomasulo_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      dispatch_valid_i,
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    input  cdb_t      ext_wb_i,
    output cdb_t      cdb_o
);

    // dispatch to rs
    logic      rs_write;
    rs_entry_t rs_entry;
    logic      rs_full;

    // rs to execute
    logic      issue_valid;
    rs_entry_t issue;
    logic      issue_ready;

    rename_table u_rename (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .rs_full_i        (rs_full),
        .cdb_i            (cdb_o),
        .rs_write_o       (rs_write),
        .rs_entry_o       (rs_entry)
    );

    alu_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .rs_write_i    (rs_write),
        .rs_entry_i    (rs_entry),
        .rs_full_o     (rs_full),
        .cdb_i         (cdb_o),
        .issue_valid_o (issue_valid),
        .issue_o       (issue),
        .issue_ready_i (issue_ready)
    );

    // also arbitrates the shared bus
    alu_unit u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .issue_ready_o (issue_ready),
        .ext_wb_i      (ext_wb_i),
        .cdb_o         (cdb_o)
    );

endmodule

/* src/alu_rs.sv */
`timescale 1ns/1ns

module alu_rs
    import tomasulo_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      rs_write_i,
    input  rs_entry_t rs_entry_i,
    output logic      rs_full_o,
    input  cdb_t      cdb_i,
    output logic      issue_valid_o,
    output rs_entry_t issue_o,
    input  logic      issue_ready_i
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    rs_entry_t           entry_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] in_use_q;
    logic [RS_DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    issue_idx;
    logic                issue_found;
    logic                do_write;
    logic                do_issue;

    // fill a waiting operand from a matching broadcast
    function automatic operand_t snoop(input operand_t opnd, input cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign rs_full_o = &in_use_q;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_vec[i] = in_use_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready;
        end
    end

    // scan downwards so the lowest index is the one left standing
    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!in_use_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        issue_idx   = '0;
        issue_found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_idx   = IDX_W'(i);
                issue_found = 1'b1;
            end
        end
    end

    assign issue_valid_o = issue_found;
    assign issue_o       = entry_q[issue_idx];

    assign do_write = rs_write_i && !rs_full_o;
    assign do_issue = issue_found && issue_ready_i;

    // entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            // only stored entries snoop, a new one already got the bypass
            if (in_use_q[i]) begin
                entry_q[i].src1 <= snoop(entry_q[i].src1, cdb_i);
                entry_q[i].src2 <= snoop(entry_q[i].src2, cdb_i);
            end
        end
        if (do_write) begin
            entry_q[free_idx] <= rs_entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_use_q <= '0;
        end else if (flush_i) begin
            in_use_q <= '0;
        end else begin
            if (do_issue) begin
                in_use_q[issue_idx] <= 1'b0;
            end
            // free slot is never the issuing one, both may happen together
            if (do_write) begin
                in_use_q[free_idx] <= 1'b1;
            end
        end
    end

endmodule

/* src/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit
    import tomasulo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      issue_valid_i,
    input  rs_entry_t issue_i,
    output logic      issue_ready_o,
    input  cdb_t      ext_wb_i,
    output cdb_t      cdb_o
);

    logic             res_valid_q;
    logic [TAG_W-1:0] res_tag_q;
    logic [XLEN-1:0]  res_val_q;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [4:0]       shamt;
    logic [XLEN-1:0]  alu_result;
    logic             take;

    assign op_a  = issue_i.src1.value;
    assign op_b  = issue_i.src2.value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (issue_i.op)
            op_add:  alu_result = op_a + op_b;
            op_sub:  alu_result = op_a - op_b;
            op_and:  alu_result = op_a & op_b;
            op_or:   alu_result = op_a | op_b;
            op_xor:  alu_result = op_a ^ op_b;
            op_sll:  alu_result = op_a << shamt;
            op_srl:  alu_result = op_a >> shamt;
            op_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            op_slt:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            op_sltu: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default: alu_result = '0;
        endcase
    end

    // blocked only when the held result loses the bus this cycle
    assign issue_ready_o = !(res_valid_q && ext_wb_i.valid);
    assign take          = issue_valid_i && issue_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else if (take) begin
            res_valid_q <= 1'b1;
        end else if (!ext_wb_i.valid) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_tag_q <= issue_i.dest;
            res_val_q <= alu_result;
        end
    end

    // external producer has priority on the bus
    always_comb begin
        if (ext_wb_i.valid) begin
            cdb_o = ext_wb_i;
        end else begin
            cdb_o.valid = res_valid_q;
            cdb_o.tag   = res_tag_q;
            cdb_o.value = res_val_q;
        end
    end

endmodule

/* src/rename_table.sv */
`timescale 1ns/1ns

module rename_table
    import tomasulo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      dispatch_valid_i,
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    input  logic      rs_full_i,
    input  cdb_t      cdb_i,
    output logic      rs_write_o,
    output rs_entry_t rs_entry_o
);

    logic [NUM_ARCH_REGS-1:0] busy_q;
    logic [TAG_W-1:0]         reg_tag_q [NUM_ARCH_REGS];
    logic [XLEN-1:0]          reg_val_q [NUM_ARCH_REGS];
    logic [TAG_W-1:0]         next_tag_q;
    logic [NUM_TAGS-1:0]      in_flight_q;
    logic                     accept;

    // value, pending tag, or value bypassed from this cycle's broadcast
    function automatic operand_t read_src(input logic [REG_W-1:0] r);
        operand_t opnd;
        opnd.ready = 1'b1;
        opnd.tag   = '0;
        opnd.value = reg_val_q[r];
        if (r == '0) begin
            opnd.value = '0;
        end else if (busy_q[r]) begin
            opnd.tag = reg_tag_q[r];
            if (cdb_i.valid && cdb_i.tag == reg_tag_q[r]) begin
                opnd.value = cdb_i.value;
            end else begin
                opnd.ready = 1'b0;
            end
        end
        return opnd;
    endfunction

    // stall while the rs is full or the next tag has not been broadcast yet
    assign dispatch_ready_o = !rs_full_i && !in_flight_q[next_tag_q];
    assign accept           = dispatch_valid_i && dispatch_ready_o;

    // external ops take a tag but never occupy an rs slot
    assign rs_write_o = accept && (dispatch_i.op != op_ext);

    always_comb begin
        rs_entry_o.op   = dispatch_i.op;
        rs_entry_o.dest = next_tag_q;
        rs_entry_o.src1 = read_src(dispatch_i.rs1);
        rs_entry_o.src2 = read_src(dispatch_i.rs2);
        if (dispatch_i.use_imm) begin
            rs_entry_o.src2.ready = 1'b1;
            rs_entry_o.src2.tag   = '0;
            rs_entry_o.src2.value = dispatch_i.imm;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= '0;
            next_tag_q  <= '0;
            in_flight_q <= '0;
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                reg_tag_q[r] <= '0;
                reg_val_q[r] <= '0;
            end
        end else if (flush_i) begin
            // architectural values survive a flush
            busy_q      <= '0;
            next_tag_q  <= '0;
            in_flight_q <= '0;
        end else begin
            if (cdb_i.valid) begin
                in_flight_q[cdb_i.tag] <= 1'b0;
                for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                    if (busy_q[r] && reg_tag_q[r] == cdb_i.tag) begin
                        reg_val_q[r] <= cdb_i.value;
                        busy_q[r]    <= 1'b0;
                    end
                end
            end
            // later assignment wins, so a new rename of rd overrides the release
            if (accept) begin
                in_flight_q[next_tag_q] <= 1'b1;
                next_tag_q              <= next_tag_q + 1'b1;
                if (dispatch_i.rd != '0) begin
                    busy_q[dispatch_i.rd]    <= 1'b1;
                    reg_tag_q[dispatch_i.rd] <= next_tag_q;
                end
            end
        end
    end

endmodule

/* src/tomasulo_pkg.sv */
package tomasulo_pkg;

    // datapath and register file sizes
    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 16;
    localparam int REG_W         = $clog2(NUM_ARCH_REGS);

    // result tags, handed out round-robin
    localparam int TAG_W    = 4;
    localparam int NUM_TAGS = 1 << TAG_W;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        // result supplied by the external producer on the cdb
        op_ext  = 4'd10
    } alu_op_e;

    // instruction as it arrives at dispatch
    typedef struct packed {
        alu_op_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  imm;
        logic             use_imm;
    } dispatch_t;

    // source operand after renaming
    // value is only meaningful once ready is set
    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        alu_op_e          op;
        logic [TAG_W-1:0] dest;
        operand_t         src1;
        operand_t         src2;
    } rs_entry_t;

    // common data bus broadcast
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

endpackage
